// File: project.f
hw/sd_datin_pkg.sv
hw/datin_word_fifo.sv
hw/datin_block_tracker.sv
hw/host_regs_ctrl.sv
hw/sd_datin_top.sv
test/tb_clock_gen.sv
test/sd_datin_assertions.sv
test/tb_sd_datin.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sd_datin -f project.f -o tb_sd_datin

# The simulation status is not used here, the log decides
./obj_dir/tb_sd_datin 2>&1 | tee sim.log

if grep -qF 'All tests passed!' sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi

// File: test/tb_sd_datin.sv
`timescale 1ns/100ps

module tb_sd_datin
    import sd_datin_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) ();
    localparam int N_RANDOM    = 300;
    localparam int N_BLOCK     = 4 * BLOCK_WORDS;
    localparam int N_LED       = 24;
    localparam int N_TRANS     = 2 * N_RANDOM + 4 * FIFO_DEPTH + 2 * N_BLOCK + 3 * N_LED + 60;
    localparam int CYCLE_BOUND = 40;                    // Cycles allowed per transaction

    logic              sd_datInWrite_clk;
    logic              sd_datInWrite_rst_;
    datin_word_t       datin;
    logic              datin_ready;
    axil_req_t         axil_req;
    axil_rsp_t         axil_rsp;
    logic [3:0]        led;

    integer            seed = 32'heb00_5c8c;
    logic [WORD_W-1:0] model_q[$];
    int                model_idx    = 0;
    logic [15:0]       model_blocks = 16'd0;
    logic [3:0]        model_mode   = 4'h0;
    logic [3:0]        model_led    = 4'h0;

    tb_clock_gen i_clk_gen (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_)
    );

    sd_datin_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_dut (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .datin              (datin),
        .datin_ready        (datin_ready),
        .axil_req           (axil_req),
        .axil_rsp           (axil_rsp),
        .led                (led)
    );

    // ====================
    // Compare tasks
    // ====================
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_status(input datin_status_t got, input datin_status_t exp);
        if (got !== exp) begin
            $display("FAILED status: got 0x%08h, expected 0x%08h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%04h, expected 0x%04h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_led(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED datin_ready: got 0x%0h, expected 0x%0h", got, exp);
            stop_run();
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic datin_status_t model_status();
        datin_status_t s;
        s.fifo_level  = 8'(model_q.size());
        s.fifo_empty  = (model_q.size() == 0);
        s.fifo_full   = (model_q.size() == FIFO_DEPTH);
        s.access_mode = model_mode;
        s.reserved    = 2'b00;
        s.block_count = model_blocks;
        return s;
    endfunction

    task automatic model_accept(input logic [WORD_W-1:0] data);
        model_q.push_back(data);
        if (model_idx == CMD6_WORD_IDX) model_mode = data[ACCESS_MODE_LSB +: 4];
        if (model_idx == BLOCK_WORDS - 1) begin
            model_idx    = 0;
            model_blocks = model_blocks + 16'd1;       // Wraps like the 16-bit field
        end else begin
            model_idx = model_idx + 1;
        end
    endtask

    // ====================
    // Bus drivers
    // ====================
    // One word on the SD side; ready is sampled mid-cycle before the accepting edge
    task automatic offer_word(input logic [WORD_W-1:0] data);
        logic accepted;
        @(posedge sd_datInWrite_clk);
        datin.trigger <= 1'b1;
        datin.data    <= data;
        @(negedge sd_datInWrite_clk);
        accepted = datin_ready;
        check_ready(accepted, model_q.size() < FIFO_DEPTH);
        @(posedge sd_datInWrite_clk);
        datin.trigger <= 1'b0;
        if (accepted) model_accept(data);
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
        @(posedge sd_datInWrite_clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= 1'b0;
        @(negedge sd_datInWrite_clk);
        while (!axil_rsp.arready) @(negedge sd_datInWrite_clk);
        @(posedge sd_datInWrite_clk);                   // AR handshake edge
        axil_req.arvalid <= 1'b0;
        axil_req.rready  <= 1'b1;
        @(negedge sd_datInWrite_clk);
        while (!axil_rsp.rvalid) @(negedge sd_datInWrite_clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge sd_datInWrite_clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
        @(posedge sd_datInWrite_clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.wvalid  <= 1'b1;
        axil_req.bready  <= 1'b0;
        @(negedge sd_datInWrite_clk);
        while (!axil_rsp.awready) @(negedge sd_datInWrite_clk);
        @(posedge sd_datInWrite_clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        axil_req.bready  <= 1'b1;
        @(negedge sd_datInWrite_clk);
        while (!axil_rsp.bvalid) @(negedge sd_datInWrite_clk);
        check_resp("bresp", axil_rsp.bresp, exp_resp);
        @(posedge sd_datInWrite_clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_status();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(REG_STATUS, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_status(datin_status_t'(data), model_status());
    endtask

    task automatic read_fifo();
        logic [31:0]       data;
        logic [1:0]        resp;
        logic [WORD_W-1:0] exp_word;
        axil_read(REG_FIFO_DATA, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        if (model_q.size() == 0) begin
            check_word("rdata[31:16]", data[31:16], 16'h0001);
            check_word("rdata[15:0]", data[15:0], 16'h0000);
        end else begin
            exp_word = model_q.pop_front();
            check_word("rdata[31:16]", data[31:16], 16'h0000);
            check_word("rdata[15:0]", data[15:0], exp_word);
        end
    endtask

    task automatic read_led();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(REG_LED, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_led("rdata[3:0]", data[3:0], model_led);
        check_led("led", led, model_led);
    endtask

    task automatic drain_fifo();
        while (model_q.size() != 0) read_fifo();
        read_fifo();                                    // One empty read at the end
    endtask

    initial begin
        repeat (16 + N_TRANS * CYCLE_BOUND) @(posedge sd_datInWrite_clk);
        $display("Watchdog expired before the tests finished");
        stop_run();
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  addr;
        logic [3:0]  strb;
        datin    <= '0;
        axil_req <= '0;
        wait (sd_datInWrite_rst_ === 1'b1);

        read_status();
        read_led();
        @(negedge sd_datInWrite_clk);
        if (datin_ready !== 1'b1) begin
            $display("datin_ready is not high after reset");
            stop_run();
        end

        // Random words mixed with host reads
        repeat (N_RANDOM) begin
            if (($random(seed) & 7) < 5) offer_word(16'($random(seed)));
            else read_fifo();
            if (($random(seed) & 15) == 0) read_status();
            repeat ($random(seed) & 1) @(posedge sd_datInWrite_clk);
        end
        drain_fifo();
        read_status();

        // Overfill with no host reads
        repeat (FIFO_DEPTH + 6) offer_word(16'($random(seed)));
        @(negedge sd_datInWrite_clk);
        if (datin_ready !== 1'b0 || model_q.size() != FIFO_DEPTH) begin
            $display("FIFO did not stop at its depth of %0d words", FIFO_DEPTH);
            stop_run();
        end
        read_status();
        drain_fifo();

        // Whole blocks with reads that keep the FIFO from filling
        repeat (N_BLOCK) begin
            offer_word(16'($random(seed)));
            if (model_q.size() > FIFO_DEPTH / 2) read_fifo();
        end
        read_status();

        repeat (N_LED) begin
            data = $random(seed);
            strb = 4'($random(seed));
            write_reg(REG_LED, data, strb, RESP_OKAY);
            if (strb[0]) model_led = data[3:0];
            read_led();
        end

        // Unmapped addresses never end in 2'b00
        repeat (12) begin
            addr = 4'($random(seed));
            if (addr[1:0] == 2'b00) addr[0] = 1'b1;
            write_reg(addr, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
            axil_read(addr, data, resp);
            check_resp("rresp", resp, RESP_SLVERR);
            check_word("rdata[31:16]", data[31:16], 16'h0000);
            check_word("rdata[15:0]", data[15:0], 16'h0000);
        end
        write_reg(REG_STATUS, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
        read_status();
        read_led();

        write_reg(REG_CONTROL, 32'h0000_0000, 4'hF, RESP_OKAY);  // Bit 0 clear has no effect
        read_status();
        write_reg(REG_CONTROL, 32'h0000_0001, 4'hF, RESP_OKAY);
        model_blocks = 16'd0;
        read_status();

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: test/sd_datin_assertions.sv
`timescale 1ns/100ps

module sd_datin_assertions
    import sd_datin_pkg::*;
(
    input logic       sd_datInWrite_clk,
    input logic       sd_datInWrite_rst_,
    input axil_req_t  axil_req,
    input axil_rsp_t  axil_rsp,
    input logic [7:0] level,
    input logic       full
);
    // ====================
    // Host handshakes
    // ====================
    bvalid_held: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    aw_w_together: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        $rose(axil_rsp.awready) |-> $rose(axil_rsp.wready))
        else $error("awready rose without wready");

    // SD side back-pressure, occupancy never grows while full
    no_store_full: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        full |=> (level <= $past(level)))
        else $error("Word stored while the FIFO was full");

endmodule

bind host_regs_ctrl sd_datin_assertions i_ctrl_checks (
    .sd_datInWrite_clk  (sd_datInWrite_clk),
    .sd_datInWrite_rst_ (sd_datInWrite_rst_),
    .axil_req           (axil_req),
    .axil_rsp           (axil_rsp),
    .level              (8'd0),
    .full               (1'b0)
);

bind datin_word_fifo sd_datin_assertions i_fifo_checks (
    .sd_datInWrite_clk  (sd_datInWrite_clk),
    .sd_datInWrite_rst_ (sd_datInWrite_rst_),
    .axil_req           ('0),
    .axil_rsp           ('0),
    .level              (level),
    .full               (full)
);

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic sd_datInWrite_clk,
    output logic sd_datInWrite_rst_
);
    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #(PERIOD_NS / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    initial begin
        sd_datInWrite_rst_ = 1'b0;                  // Held from time zero
        repeat (RESET_CYCLES) @(posedge sd_datInWrite_clk);
        sd_datInWrite_rst_ <= 1'b1;
    end

endmodule

// File: hw/sd_datin_top.sv
`timescale 1ns/100ps

module sd_datin_top
    import sd_datin_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int BLOCK_WORDS = sd_datin_pkg::BLOCK_WORDS
) (
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,
    input  datin_word_t datin,
    output logic        datin_ready,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output logic [3:0]  led
);
    logic [WORD_W-1:0] fifo_head;
    logic              fifo_empty;
    logic              fifo_full;
    logic [7:0]        fifo_level;
    logic              pop;
    logic [3:0]        access_mode;
    logic [15:0]       block_count;
    logic              clear_blocks;
    logic              accept;

    assign accept = datin.trigger && datin_ready;   // Same qualifier the FIFO stores on

    host_regs_ctrl i_ctrl (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .axil_req           (axil_req),
        .axil_rsp           (axil_rsp),
        .fifo_head          (fifo_head),
        .fifo_empty         (fifo_empty),
        .fifo_full          (fifo_full),
        .fifo_level         (fifo_level),
        .pop                (pop),
        .access_mode        (access_mode),
        .block_count        (block_count),
        .clear_blocks       (clear_blocks),
        .led                (led)
    );

    datin_word_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .wr                 (datin),
        .ready              (datin_ready),
        .pop                (pop),
        .head               (fifo_head),
        .empty              (fifo_empty),
        .full               (fifo_full),
        .level              (fifo_level)
    );

    datin_block_tracker #(
        .BLOCK_WORDS(BLOCK_WORDS)
    ) i_tracker (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .accept             (accept),
        .word               (datin.data),
        .clear_blocks       (clear_blocks),
        .access_mode        (access_mode),
        .block_count        (block_count)
    );

endmodule

// File: hw/host_regs_ctrl.sv
`timescale 1ns/100ps

module host_regs_ctrl
    import sd_datin_pkg::*;
(
    input  logic              sd_datInWrite_clk,
    input  logic              sd_datInWrite_rst_,
    input  axil_req_t         axil_req,
    output axil_rsp_t         axil_rsp,
    input  logic [WORD_W-1:0] fifo_head,
    input  logic              fifo_empty,
    input  logic              fifo_full,
    input  logic [7:0]        fifo_level,
    output logic              pop,
    input  logic [3:0]        access_mode,
    input  logic [15:0]       block_count,
    output logic              clear_blocks,
    output logic [3:0]        led
);
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   wr_ok;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   rvalid;
    logic [1:0]             rresp;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic [1:0]             rd_resp;
    datin_status_t          status;

    // ====================
    // Write channel
    // ====================
    // AW and W are taken together; a pending B response stalls both
    assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign wr_ok = (axil_req.awaddr == REG_LED) || (axil_req.awaddr == REG_CONTROL);

    assign clear_blocks = wr_hs && (axil_req.awaddr == REG_CONTROL) && axil_req.wdata[0];

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            bvalid <= 1'b0;
            led    <= 4'h0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end

            if (wr_hs && (axil_req.awaddr == REG_LED) && axil_req.wstrb[0]) begin
                led <= axil_req.wdata[3:0];
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ====================
    // Read channel
    // ====================
    assign rd_hs = axil_req.arvalid && !rvalid;

    // Head word leaves the FIFO on the AR handshake itself
    assign pop = rd_hs && (axil_req.araddr == REG_FIFO_DATA) && !fifo_empty;

    always_comb begin
        status.fifo_level  = fifo_level;
        status.fifo_empty  = fifo_empty;
        status.fifo_full   = fifo_full;
        status.access_mode = access_mode;
        status.reserved    = 2'b00;
        status.block_count = block_count;
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            REG_STATUS: begin
                rd_data = status;
            end
            REG_FIFO_DATA: begin
                rd_data[WORD_W] = fifo_empty;           // Empty flag above the word
                if (!fifo_empty) begin
                    rd_data[WORD_W-1:0] = fifo_head;
                end
            end
            REG_LED: begin
                rd_data[3:0] = led;
            end
            REG_CONTROL: begin
                rd_data = '0;                           // Write-only strobes
            end
            default: begin
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            rvalid <= 1'b0;
        end else begin
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (rd_hs) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Slave outputs
    always_comb begin
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = rd_hs;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

endmodule

// File: hw/datin_block_tracker.sv
`timescale 1ns/100ps

module datin_block_tracker
    import sd_datin_pkg::*;
#(
    parameter int BLOCK_WORDS = sd_datin_pkg::BLOCK_WORDS
) (
    input  logic              sd_datInWrite_clk,
    input  logic              sd_datInWrite_rst_,
    input  logic              accept,
    input  logic [WORD_W-1:0] word,
    input  logic              clear_blocks,
    output logic [3:0]        access_mode,
    output logic [15:0]       block_count
);
    localparam int IDX_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

    logic [IDX_W-1:0] word_idx;
    logic             last_word;
    logic             mode_word;

    assign last_word = accept && (word_idx == IDX_W'(BLOCK_WORDS-1));
    assign mode_word = accept && (word_idx == IDX_W'(CMD6_WORD_IDX));

    // ====================
    // Word position in block
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx <= '0;
        end else if (accept) begin
            word_idx <= last_word ? '0 : word_idx + 1'b1;
        end
    end

    // CMD6 switch status carries the access mode in word 8
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            access_mode <= 4'h0;
        end else if (mode_word) begin
            access_mode <= word[ACCESS_MODE_LSB +: 4];
        end
    end

    // ====================
    // Completed blocks
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            block_count <= 16'd0;
        end else begin
            if (clear_blocks) begin
                block_count <= last_word ? 16'd1 : 16'd0;   // Completion still counts
            end else if (last_word) begin
                block_count <= block_count + 16'd1;         // Wraps at 16 bits
            end
        end
    end

endmodule

// File: hw/datin_word_fifo.sv
`timescale 1ns/100ps

module datin_word_fifo
    import sd_datin_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic              sd_datInWrite_clk,
    input  logic              sd_datInWrite_rst_,
    input  datin_word_t       wr,
    output logic              ready,
    input  logic              pop,
    output logic [WORD_W-1:0] head,
    output logic              empty,
    output logic              full,
    output logic [7:0]        level
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [7:0]        count;
    logic              store;
    logic              take;

    assign full  = (count == 8'(DEPTH));
    assign empty = (count == 8'd0);
    assign ready = !full;               // Pop this cycle frees space next edge
    assign level = count;
    assign head  = mem[rd_ptr];         // Oldest word, no read latency

    assign store = wr.trigger && ready;
    assign take  = pop && !empty;

    always_ff @(posedge sd_datInWrite_clk) begin
        if (store) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // ====================
    // Pointers and occupancy
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 8'd0;
        end else begin
            if (store) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({store, take})
                2'b10:   count <= count + 8'd1;
                2'b01:   count <= count - 8'd1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

endmodule

// File: hw/sd_datin_pkg.sv
package sd_datin_pkg;

    // ====================
    // Widths and block layout
    // ====================
    localparam int WORD_W          = 16;
    localparam int BLOCK_WORDS     = 32;    // 512-bit block
    localparam int CMD6_WORD_IDX   = 8;
    localparam int ACCESS_MODE_LSB = 8;     // 4-bit field

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // ====================
    // Register map
    // ====================
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS    = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_FIFO_DATA = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_LED       = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_CONTROL   = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Word stream from the SD controller
    typedef struct packed {
        logic              trigger;
        logic [WORD_W-1:0] data;
    } datin_word_t;

    // Master side of the host port
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [3:0]             wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Slave side of the host port
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

    // Status word, MSB first
    typedef struct packed {
        logic [7:0]  fifo_level;
        logic        fifo_empty;
        logic        fifo_full;
        logic [3:0]  access_mode;
        logic [1:0]  reserved;
        logic [15:0] block_count;
    } datin_status_t;

endpackage
